/* Makefile */
TOP := tb_fp32_uart_loop
SRCS := $(wildcard source/*.sv source/*.svh bench/*.sv bench/*.svh)

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall +incdir+source source/fp32_link_pkg.sv \
		source/uart_byte_rx.sv source/record_assembler.sv source/uart_word_tx.sv \
		source/fp32_uart_loop.sv --top-module fp32_uart_loop

obj_dir/V$(TOP): build.f $(SRCS)
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* bench/uart_line_tasks.svh */
`ifndef UART_LINE_TASKS_SVH
`define UART_LINE_TASKS_SVH

// holds the rx line for one bit time, entered and left on a falling edge
task automatic drive_bit(input logic level);
    uart_rx = level;
    repeat (clks_per_bit) @(negedge CLK_I);
endtask

// start, eight data bits LSB first, stop
task automatic send_frame(input logic [7:0] data, input bit stop_ok);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < 8; i++) begin
        drive_bit(data[i]);
    end
    drive_bit(stop_ok ? 1'b1 : 1'b0); // low stop bit when a framing error is wanted
endtask

// short low pulse followed by one bit time of idle line
task automatic send_glitch(input int low_clks);
    uart_rx = 1'b0;
    repeat (low_clks) @(negedge CLK_I);
    drive_bit(1'b1);
endtask

// waits for a start bit on the tx line and samples each bit at its middle
task automatic receive_frame(output logic [7:0] data, output bit framing_ok);
    int i;
    framing_ok = 1'b1;
    while (uart_tx !== 1'b0) begin
        @(negedge CLK_I);
    end
    repeat (clks_per_bit / 2) @(negedge CLK_I);
    if (uart_tx !== 1'b0) begin
        framing_ok = 1'b0;
    end
    for (i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge CLK_I);
        data[i] = uart_tx;
    end
    repeat (clks_per_bit) @(negedge CLK_I);
    if (uart_tx !== 1'b1) begin
        framing_ok = 1'b0; // stop bit
    end
endtask

`endif

/* bench/tb_fp32_uart_loop.sv */
`include "uart_consts.svh"

module tb_fp32_uart_loop;
    import fp32_link_pkg::*;

    localparam int clks_per_bit = 16;
    localparam int clk_period   = 40;
    localparam int num_entries  = 7;
    localparam int timeout      = 2 * num_entries * 13 * 10 * clks_per_bit * clk_period;

    logic CLK_I;
    logic RSTL_I;
    logic uart_rx;
    logic uart_tx;

    int    error_count;
    fp32_t rx_words [$];
    fp32_t exp_words [$];
    string exp_names [$];

    // stimulus table, byte 0 of a record in the low bits
    string       entry_name   [num_entries];
    logic [95:0] entry_bytes  [num_entries];
    fp32_t       entry_expect [num_entries];
    int          entry_bad    [num_entries]; // byte index with a low stop bit, -1 for none
    bit          entry_glitch [num_entries];
    bit          entry_rand   [num_entries];

    fp32_uart_loop #(
        .clks_per_bit (clks_per_bit)
    ) u_fp32_uart_loop (
        .CLK_I   (CLK_I),
        .RSTL_I  (RSTL_I),
        .uart_rx (uart_rx),
        .uart_tx (uart_tx)
    );

    `include "uart_line_tasks.svh"

    always #(clk_period / 2) CLK_I = ~CLK_I;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_table();
        int i;
        int j;
        entry_name = '{"fixed_record", "random_0", "random_1", "random_2",
                       "bad_stop_byte6", "glitch_start", "bad_stop_byte11"};
        entry_bad    = '{-1, -1, -1, -1, 6, -1, 11};
        entry_glitch = '{0, 0, 0, 0, 0, 1, 0};
        entry_rand   = '{0, 1, 1, 1, 0, 0, 0};
        entry_bytes[0]  = 96'h40a00000_40000000_3fc00000;
        entry_expect[0] = 32'h3fc00000;
        entry_bytes[4]  = 96'hc1200000_bf800000_42f6e979;
        entry_expect[4] = 32'h42f6e979;
        entry_bytes[5]  = 96'h3f800000_3f800000_c0490fdb;
        entry_expect[5] = 32'hc0490fdb;
        entry_bytes[6]  = 96'h00000000_7f7fffff_00000001;
        entry_expect[6] = 32'h00000001;
        for (i = 0; i < num_entries; i++) begin
            if (entry_rand[i]) begin
                for (j = 0; j < 12; j++) begin
                    entry_bytes[i][j*8 +: 8] = 8'($urandom());
                end
                entry_expect[i] = entry_bytes[i][31:0]; // operand A is the first four bytes
            end
        end
    endtask

    task automatic apply_entry(input int idx);
        int j;
        if (entry_glitch[idx]) begin
            send_glitch(3);
        end
        if (entry_bad[idx] >= 0) begin
            // partial record of other bytes, cut short by the bad frame
            for (j = 0; j <= entry_bad[idx]; j++) begin
                send_frame(~entry_bytes[idx][j*8 +: 8], j != entry_bad[idx]);
            end
            drive_bit(1'b1);
        end
        for (j = 0; j < 12; j++) begin
            send_frame(entry_bytes[idx][j*8 +: 8], 1'b1);
        end
        exp_words.push_back(entry_expect[idx]);
        exp_names.push_back(entry_name[idx]);
    endtask

    initial begin : stimulus
        int i;
        int k;
        int low_cycles;
        error_count = 0;
        CLK_I       = 1'b0;
        RSTL_I      = 1'b0;
        uart_rx     = 1'b1;
        void'($urandom(16));
        load_table();
        repeat (16) @(negedge CLK_I);
        RSTL_I = 1'b1;

        // line must stay idle with nothing sent
        low_cycles = 0;
        repeat (4 * clks_per_bit) begin
            @(negedge CLK_I);
            if (uart_tx !== 1'b1) begin
                low_cycles++;
            end
        end
        check_value("idle_after_reset", 0, low_cycles);

        for (i = 0; i < num_entries; i++) begin
            apply_entry(i);
        end
        while (rx_words.size() < exp_words.size()) begin
            @(negedge CLK_I);
        end
        repeat (44 * clks_per_bit) @(negedge CLK_I); // room for a stray extra word

        check_value("word_count", exp_words.size(), rx_words.size());
        for (k = 0; k < exp_words.size(); k++) begin
            if (k < rx_words.size()) begin
                check_value(exp_names[k], exp_words[k], rx_words[k]);
            end
        end
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // collects four frames per word from the tx line
    initial begin : monitor
        logic [7:0] frame_byte;
        bit         frame_ok;
        fp32_t      word;
        int         b;
        wait (RSTL_I === 1'b1);
        @(negedge CLK_I);
        forever begin
            for (b = 0; b < 4; b++) begin
                receive_frame(frame_byte, frame_ok);
                if (!frame_ok) begin
                    error_count++;
                    $display("framing fault on uart_tx: start bit not low or stop bit not high");
                end
                word[b*8 +: 8] = frame_byte;
            end
            rx_words.push_back(word);
        end
    end

    initial begin : watchdog
        #(timeout);
        $display("timeout: the run did not finish within %0d time units", timeout);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* build.f */
+incdir+source
+incdir+bench
source/fp32_link_pkg.sv
source/uart_byte_rx.sv
source/record_assembler.sv
source/uart_word_tx.sv
source/fp32_uart_loop.sv
bench/tb_fp32_uart_loop.sv

/* source/fp32_link_pkg.sv */
`include "uart_consts.svh"

package fp32_link_pkg;

    // one data byte as it comes off the line
    typedef logic [`UART_BITS_PER_BYTE-1:0] byte_t;

    // one fp32 operand, byte 0 in the low bits
    typedef logic [`UART_BYTES_PER_WORD*`UART_BITS_PER_BYTE-1:0] fp32_t;

    // clocks within one bit time, enough for the default period
    typedef logic [15:0] bit_cnt_t;

endpackage

/* source/fp32_uart_loop.sv */
`include "uart_consts.svh"

module fp32_uart_loop #(
    parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
    input  logic CLK_I,
    input  logic RSTL_I,
    input  logic uart_rx,
    output logic uart_tx
);
    import fp32_link_pkg::*;

    logic  rx_byte_stb;
    byte_t rx_byte;
    logic  rx_frame_err;
    logic  word_stb;
    fp32_t word;

    uart_byte_rx #(
        .clks_per_bit (clks_per_bit)
    ) u_uart_byte_rx (
        .CLK_I        (CLK_I),
        .RSTL_I       (RSTL_I),
        .uart_rx      (uart_rx),
        .rx_byte_stb  (rx_byte_stb),
        .rx_byte      (rx_byte),
        .rx_frame_err (rx_frame_err)
    );

    record_assembler u_record_assembler (
        .CLK_I        (CLK_I),
        .RSTL_I       (RSTL_I),
        .rx_byte_stb  (rx_byte_stb),
        .rx_byte      (rx_byte),
        .rx_frame_err (rx_frame_err),
        .word_stb     (word_stb),
        .word         (word)
    );

    uart_word_tx #(
        .clks_per_bit (clks_per_bit)
    ) u_uart_word_tx (
        .CLK_I    (CLK_I),
        .RSTL_I   (RSTL_I),
        .word_stb (word_stb),
        .word     (word),
        .uart_tx  (uart_tx)
    );

endmodule

/* source/record_assembler.sv */
`include "uart_consts.svh"

module record_assembler (
    input  logic                 CLK_I,
    input  logic                 RSTL_I,
    input  logic                 rx_byte_stb,
    input  fp32_link_pkg::byte_t rx_byte,
    input  logic                 rx_frame_err,
    output logic                 word_stb,
    output fp32_link_pkg::fp32_t word
);
    import fp32_link_pkg::*;

    localparam int cnt_w = $clog2(`UART_BYTES_PER_RECORD);
    localparam logic [cnt_w-1:0] last_byte = cnt_w'(`UART_BYTES_PER_RECORD - 1);
    localparam logic [cnt_w-1:0] word_end  = cnt_w'(`UART_BYTES_PER_WORD);

    logic [cnt_w-1:0] byte_cnt;
    logic             good_byte;
    fp32_t            op_a; // operand A while the record is still arriving

    assign good_byte = rx_byte_stb & ~rx_frame_err;

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            byte_cnt <= '0;
            word_stb <= 1'b0;
        end else begin
            word_stb <= 1'b0;
            if (rx_byte_stb && rx_frame_err) begin
                byte_cnt <= '0; // drop the partial record
            end else if (good_byte) begin
                if (byte_cnt == last_byte) begin
                    byte_cnt <= '0;
                    word_stb <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // B and C bytes are only counted
    always_ff @(posedge CLK_I) begin
        if (good_byte && byte_cnt < word_end) begin
            op_a[byte_cnt[1:0]*`UART_BITS_PER_BYTE +: `UART_BITS_PER_BYTE] <= rx_byte;
        end
        if (good_byte && byte_cnt == last_byte) begin
            word <= op_a; // held until the next record completes
        end
    end

endmodule

/* source/uart_byte_rx.sv */
`include "uart_consts.svh"

module uart_byte_rx #(
    parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
    input  logic                 CLK_I,
    input  logic                 RSTL_I,
    input  logic                 uart_rx,
    output logic                 rx_byte_stb,
    output fp32_link_pkg::byte_t rx_byte,
    output logic                 rx_frame_err
);
    import fp32_link_pkg::*;

    localparam int       bit_idx_w = $clog2(`UART_BITS_PER_BYTE);
    localparam bit_cnt_t half_cnt  = bit_cnt_t'(clks_per_bit / 2 - 1);
    localparam bit_cnt_t full_cnt  = bit_cnt_t'(clks_per_bit - 1);
    localparam logic [bit_idx_w-1:0] last_bit = bit_idx_w'(`UART_BITS_PER_BYTE - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_t;

    rx_state_t            state;
    bit_cnt_t             clk_cnt;
    logic [bit_idx_w-1:0] bit_idx;
    logic [1:0]           sync_q;
    logic                 rx_s;

    assign rx_s = sync_q[1];

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            sync_q       <= 2'b11; // line idles high
            state        <= st_idle;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            rx_byte_stb  <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            sync_q      <= {sync_q[0], uart_rx};
            rx_byte_stb <= 1'b0;
            clk_cnt     <= clk_cnt + 1'b1;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_s) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (clk_cnt == half_cnt) begin
                        clk_cnt <= '0;
                        state   <= rx_s ? st_idle : st_data; // glitch goes back to idle
                    end
                end
                st_data: begin
                    if (clk_cnt == full_cnt) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == last_bit) begin
                            state <= st_stop;
                        end
                    end
                end
                st_stop: begin
                    if (clk_cnt == full_cnt) begin
                        rx_byte_stb  <= 1'b1;
                        rx_frame_err <= ~rx_s; // stop bit must be high
                        state        <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // shift register, LSB arrives first
    always_ff @(posedge CLK_I) begin
        if (state == st_data && clk_cnt == full_cnt) begin
            rx_byte <= {rx_s, rx_byte[`UART_BITS_PER_BYTE-1:1]};
        end
    end

endmodule

/* source/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// 50 MHz clock to 115200 baud
`define UART_CLKS_PER_BIT 434

// data bits in one frame
`define UART_BITS_PER_BYTE 8

// three fp32 operands A, B and C
`define UART_BYTES_PER_RECORD 12

// one fp32 operand
`define UART_BYTES_PER_WORD 4

// idle high time after every transmitted stop bit
`define UART_IDLE_BITS 1

`endif

/* source/uart_word_tx.sv */
`include "uart_consts.svh"

module uart_word_tx #(
    parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
    input  logic                 CLK_I,
    input  logic                 RSTL_I,
    input  logic                 word_stb,
    input  fp32_link_pkg::fp32_t word,
    output logic                 uart_tx
);
    import fp32_link_pkg::*;

    localparam bit_cnt_t   full_cnt  = bit_cnt_t'(clks_per_bit - 1);
    // start, data bits, stop, then idle bits
    localparam logic [3:0] stop_bit  = 4'(`UART_BITS_PER_BYTE + 1);
    localparam logic [3:0] last_bit  = 4'(`UART_BITS_PER_BYTE + 1 + `UART_IDLE_BITS);
    localparam logic [1:0] last_byte = 2'(`UART_BYTES_PER_WORD - 1);

    logic       busy;
    bit_cnt_t   clk_cnt;
    logic [3:0] bit_idx;
    logic [1:0] byte_idx;
    fp32_t      tx_word;

    // line level for one slot after the start bit
    function automatic logic bit_level(input logic [3:0] idx, input logic [1:0] sel);
        logic [3:0] data_idx;
        data_idx = idx - 4'd1;
        if (idx < stop_bit) begin
            return tx_word[sel*`UART_BITS_PER_BYTE + data_idx];
        end
        return 1'b1; // stop and idle
    endfunction

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            uart_tx  <= 1'b1;
        end else if (!busy) begin
            if (word_stb) begin
                busy     <= 1'b1;
                clk_cnt  <= '0;
                bit_idx  <= '0;
                byte_idx <= '0;
                uart_tx  <= 1'b0; // first start bit
            end
        end else if (clk_cnt == full_cnt) begin
            clk_cnt <= '0;
            if (bit_idx == last_bit) begin
                bit_idx <= '0;
                if (byte_idx == last_byte) begin
                    busy    <= 1'b0;
                    uart_tx <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                    uart_tx  <= 1'b0; // next start bit
                end
            end else begin
                bit_idx <= bit_idx + 1'b1;
                uart_tx <= bit_level(bit_idx + 4'd1, byte_idx);
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // the word stays put while the frames go out
    always_ff @(posedge CLK_I) begin
        if (word_stb && !busy) begin
            tx_word <= word;
        end
    end

endmodule
